// ==== Bender.yml ====
package:
  name: rob

sources:
  - files:
      - rtl/rob_pkg.sv
      - rtl/rob_entry.sv
      - rtl/rob_ctl.sv
      - rtl/rob_head_sel.sv
      - rtl/rob_top.sv
  - target: test
    files:
      - tb/rob_clk_gen.sv
      - tb/rob_chk.sv
      - tb/rob_tb.sv

// ==== rtl/rob_ctl.sv ====
module rob_ctl
   import rob_pkg::*;
#(
   parameter int ROB_DEPTH = 8
) (
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 alloc_valid,
   input  t_rob_ent             head_ent,
   input  logic                 head_valid,

   output logic [ROB_DEPTH-1:0] alloc_slot,
   output logic [ROB_DEPTH-1:0] retire_now,
   output logic                 flush_now,
   output t_rob_id              head_id,
   output t_rob_id              alloc_id,
   output logic                 full
);

   localparam int ID_W  = rob_id_bits(ROB_DEPTH);
   localparam int CNT_W = ID_W + 1;

   logic [ID_W-1:0]  head_ptr;
   logic [ID_W-1:0]  tail_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_nxt;

   logic alloc_ok;
   logic retire_go;

   // Head decisions
   assign flush_now = head_valid & head_ent.d.flush_needed;
   assign retire_go = head_valid & head_ent.d.ready;

   // Allocation lost on a full ROB or a flush
   assign alloc_ok = alloc_valid & ~full & ~flush_now;

   assign full = (count == CNT_W'(ROB_DEPTH));

   // One-hot strobes to the slot array
   assign alloc_slot = {{(ROB_DEPTH-1){1'b0}}, alloc_ok} << tail_ptr;
   assign retire_now = {{(ROB_DEPTH-1){1'b0}}, retire_go} << head_ptr;

   assign head_id  = t_rob_id'(head_ptr);
   assign alloc_id = t_rob_id'(tail_ptr);

   always_comb begin
      count_nxt = count;
      if (alloc_ok && !retire_go) begin
         count_nxt = count + CNT_W'(1);
      end else if (retire_go && !alloc_ok) begin
         count_nxt = count - CNT_W'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         head_ptr <= '0;
         tail_ptr <= '0;
         count    <= '0;
      end else if (flush_now) begin
         // Whole window is discarded
         head_ptr <= '0;
         tail_ptr <= '0;
         count    <= '0;
      end else begin
         if (alloc_ok) begin
            tail_ptr <= tail_ptr + ID_W'(1);
         end
         if (retire_go) begin
            head_ptr <= head_ptr + ID_W'(1);
         end
         count <= count_nxt;
      end
   end

endmodule

// ==== rtl/rob_entry.sv ====
module rob_entry
   import rob_pkg::*;
(
   input  logic            clk,
   input  logic            reset,
   input  t_rob_id         robid,

   input  t_rob_ent_static alloc_s,
   input  logic            alloc,

   input  logic            wb_valid,
   input  t_rob_result     wb_result,

   input  logic            flush_now,
   input  logic            retire,

   output logic            e_valid,
   output t_rob_ent        rob_entry
);

   typedef enum logic [1:0] {
      ENT_IDLE,
      ENT_PEND,
      ENT_READY,
      ENT_FLUSH
   } t_ent_state;

   t_ent_state      state;
   t_ent_state      state_nxt;
   logic            wb_hit;
   t_rob_ent_static s_q;

   // Writeback addressed to this slot
   assign wb_hit = wb_valid & (wb_result.robid == robid);

   always_comb begin
      state_nxt = state;
      case (state)
         ENT_IDLE: begin
            if (alloc) state_nxt = ENT_PEND;
         end
         ENT_PEND: begin
            if (flush_now) state_nxt = ENT_IDLE;
            else if (wb_hit && wb_result.mispred) state_nxt = ENT_FLUSH;
            else if (wb_hit) state_nxt = ENT_READY;
         end
         ENT_READY: begin
            if (flush_now || retire) state_nxt = ENT_IDLE;
         end
         ENT_FLUSH: begin
            if (flush_now) state_nxt = ENT_IDLE;
         end
         default: state_nxt = ENT_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) state <= ENT_IDLE;
      else state <= state_nxt;
   end

   always_ff @(posedge clk) begin
      if (alloc) s_q <= alloc_s;
   end

   assign e_valid                = (state != ENT_IDLE);
   assign rob_entry.s            = s_q;
   assign rob_entry.d.ready      = (state == ENT_READY);
   assign rob_entry.d.flush_needed = (state == ENT_FLUSH);

endmodule

// ==== rtl/rob_head_sel.sv ====
module rob_head_sel
   import rob_pkg::*;
#(
   parameter int ROB_DEPTH = 8
) (
   input  logic                           clk,
   input  logic                           reset,

   input  t_rob_ent [ROB_DEPTH-1:0]       ents,
   input  logic [ROB_DEPTH-1:0]           valids,
   input  t_rob_id                        head_id,
   input  logic [ROB_DEPTH-1:0]           retire_now,
   input  logic                           flush_now,

   output t_rob_ent                       head_ent,
   output logic                           head_valid,
   output logic                           retire_valid,
   output t_rob_ent_static                retire_s,
   output logic                           flush_valid,
   output logic [15:0]                    flush_pc
);

   localparam int ID_W = rob_id_bits(ROB_DEPTH);

   logic [ID_W-1:0] head_idx;

   assign head_idx   = head_id[ID_W-1:0];
   assign head_ent   = ents[head_idx];
   assign head_valid = valids[head_idx];

   // Output pulses
   always_ff @(posedge clk) begin
      if (reset) begin
         retire_valid <= 1'b0;
         flush_valid  <= 1'b0;
      end else begin
         retire_valid <= |retire_now;
         flush_valid  <= flush_now;
      end
   end

   always_ff @(posedge clk) begin
      retire_s <= head_ent.s;
      flush_pc <= head_ent.s.pc;
   end

endmodule

// ==== rtl/rob_pkg.sv ====
package rob_pkg;

   // Default id width for a depth of 8
   parameter int ROB_ID_W = 3;

   typedef logic [ROB_ID_W-1:0] t_rob_id;

   // Captured once at allocation
   typedef struct packed {
      logic [15:0] pc;
      logic [4:0]  rd;
   } t_rob_ent_static;

   // Execute writeback tagged by ROB id
   typedef struct packed {
      t_rob_id robid;
      logic    mispred;
   } t_rob_result;

   typedef struct packed {
      logic ready;
      logic flush_needed;
   } t_rob_ent_dyn;

   // Visible slot contents
   typedef struct packed {
      t_rob_ent_static s;
      t_rob_ent_dyn    d;
   } t_rob_ent;

   // log2 of a power of two depth
   function automatic int rob_id_bits(input int depth);
      int bits;
      bits = $clog2(depth);
      return bits;
   endfunction

endpackage

// ==== rtl/rob_top.sv ====
module rob_top
   import rob_pkg::*;
#(
   parameter int ROB_DEPTH = 8
) (
   input  logic            clk,
   input  logic            reset,

   input  logic            alloc_valid,
   input  t_rob_ent_static alloc_s,
   output t_rob_id         alloc_id,
   output logic            full,

   input  logic            wb_valid,
   input  t_rob_result     wb_result,

   output logic            retire_valid,
   output t_rob_ent_static retire_s,
   output logic            flush_valid,
   output logic [15:0]     flush_pc
);

   logic [ROB_DEPTH-1:0]     alloc_slot;
   logic [ROB_DEPTH-1:0]     retire_now;
   logic                     flush_now;
   t_rob_id                  head_id;
   t_rob_ent                 head_ent;
   logic                     head_valid;
   t_rob_ent [ROB_DEPTH-1:0] ents;
   logic [ROB_DEPTH-1:0]     valids;

   rob_ctl #(
      .ROB_DEPTH (ROB_DEPTH)
   ) rob_ctl_i (
      .clk         (clk),
      .reset       (reset),
      .alloc_valid (alloc_valid),
      .head_ent    (head_ent),
      .head_valid  (head_valid),
      .alloc_slot  (alloc_slot),
      .retire_now  (retire_now),
      .flush_now   (flush_now),
      .head_id     (head_id),
      .alloc_id    (alloc_id),
      .full        (full)
   );

   // Slot array
   for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_slot
      rob_entry rob_entry_i (
         .clk       (clk),
         .reset     (reset),
         .robid     (t_rob_id'(i)),
         .alloc_s   (alloc_s),
         .alloc     (alloc_slot[i]),
         .wb_valid  (wb_valid),
         .wb_result (wb_result),
         .flush_now (flush_now),
         .retire    (retire_now[i]),
         .e_valid   (valids[i]),
         .rob_entry (ents[i])
      );
   end

   rob_head_sel #(
      .ROB_DEPTH (ROB_DEPTH)
   ) rob_head_sel_i (
      .clk          (clk),
      .reset        (reset),
      .ents         (ents),
      .valids       (valids),
      .head_id      (head_id),
      .retire_now   (retire_now),
      .flush_now    (flush_now),
      .head_ent     (head_ent),
      .head_valid   (head_valid),
      .retire_valid (retire_valid),
      .retire_s     (retire_s),
      .flush_valid  (flush_valid),
      .flush_pc     (flush_pc)
   );

endmodule

// ==== src.f ====
rtl/rob_pkg.sv
rtl/rob_entry.sv
rtl/rob_ctl.sv
rtl/rob_head_sel.sv
rtl/rob_top.sv
tb/rob_clk_gen.sv
tb/rob_chk.sv
tb/rob_tb.sv

// ==== tb/rob_cases.txt ====
// Fields are op pc rd id mispred in hex
// Op 0 idle 1 alloc 2 writeback 3 expect retire 4 expect flush f end
1_1000_01_0_0
2_0000_00_0_0
3_1000_01_0_0
1_1010_03_0_0
1_1014_04_0_0
2_0000_00_2_0
2_0000_00_1_0
3_1010_03_0_0
3_1014_04_0_0
1_1020_06_0_0
1_1024_07_0_0
2_0000_00_4_1
2_0000_00_3_0
3_1020_06_0_0
4_1024_00_0_0
1_1030_08_0_0
1_1034_09_0_0
2_0000_00_1_0
2_0000_00_0_1
4_1030_00_0_0
1_1040_0a_0_0
1_1044_0b_0_0
1_1048_0c_0_0
1_104c_0d_0_0
1_1050_0e_0_0
1_1054_0f_0_0
1_1058_10_0_0
1_105c_11_0_0
1_1060_12_0_0
2_0000_00_0_0
3_1040_0a_0_0
1_1060_12_0_0
f_0000_00_0_0

// ==== tb/rob_chk.sv ====
module rob_chk (
   input logic clk,
   input logic reset,
   input logic retire_valid,
   input logic flush_valid,
   input logic full
);

   int n_fail = 0;

   a_no_overlap: assert property (@(posedge clk) disable iff (reset)
      !(retire_valid && flush_valid))
      else begin
         n_fail++;
         $error("retire_valid and flush_valid high in the same cycle");
      end

   // Space frees up only through a retire or a flush
   a_full_drop: assert property (@(posedge clk) disable iff (reset)
      $fell(full) |-> (retire_valid || flush_valid))
      else begin
         n_fail++;
         $error("full dropped without a retire or a flush");
      end

   // Decisions made in the first cycle out of reset
   a_quiet_after_reset: assert property (@(posedge clk)
      $fell(reset) |=> (!retire_valid && !flush_valid))
      else begin
         n_fail++;
         $error("retire or flush in the first cycle after reset");
      end

endmodule

bind rob_top rob_chk rob_chk_i (.*);

// ==== tb/rob_clk_gen.sv ====
module rob_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== tb/rob_tb.sv ====
module rob_tb
   import rob_pkg::*;
();

   localparam int ROB_DEPTH = 8;
   localparam int MAX_LINES = 64;

   // Reference queue entry and retire or flush record
   typedef struct packed {
      t_rob_ent_static s;
      t_rob_id         id;
      logic            ready;
      logic            flush_needed;
   } t_model_ent;

   logic            clk;
   logic            reset;
   logic            alloc_valid;
   t_rob_ent_static alloc_s;
   t_rob_id         alloc_id;
   logic            full;
   logic            wb_valid;
   t_rob_result     wb_result;
   logic            retire_valid;
   t_rob_ent_static retire_s;
   logic            flush_valid;
   logic [15:0]     flush_pc;

   logic [35:0]     case_mem [MAX_LINES];
   int              n_cases;
   t_model_ent      rob_q[$];
   t_rob_id         tail_id;
   t_model_ent      last_head;
   t_model_ent      predicted[$];
   t_model_ent      recorded[$];

   rob_clk_gen #(.PERIOD (4)) rob_clk_gen_i (.clk (clk));

   rob_top #(.ROB_DEPTH (ROB_DEPTH)) rob_top_i (.*);

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("Fail at %0t %s got %0h expected %0h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_outputs();
      compare("alloc_id", alloc_id, tail_id);
      compare("full", full, rob_q.size() == ROB_DEPTH);
      compare("retire_valid", retire_valid, last_head.ready);
      compare("flush_valid", flush_valid, last_head.flush_needed);
      if (last_head.ready) compare("retire_s", retire_s, last_head.s);
      if (last_head.flush_needed) compare("flush_pc", flush_pc, last_head.s.pc);
   endtask

   // Moves the reference queue across one rising edge
   task automatic model_step();
      t_model_ent ent;
      last_head = (rob_q.size() > 0) ? rob_q[0] : '0;
      ent = last_head;
      ent.id = '0;
      if (ent.flush_needed) ent.s.rd = '0;
      if (ent.ready || ent.flush_needed) predicted.push_back(ent);
      if (last_head.flush_needed) begin
         rob_q.delete();
         tail_id = '0;
         return;
      end
      foreach (rob_q[i]) begin
         ent = rob_q[i];
         // Only a pending entry takes a writeback
         if (wb_valid && ent.id == wb_result.robid && !ent.ready && !ent.flush_needed) begin
            ent.ready = !wb_result.mispred;
            ent.flush_needed = wb_result.mispred;
            rob_q[i] = ent;
         end
      end
      if (alloc_valid && rob_q.size() < ROB_DEPTH) begin
         ent = '{s: alloc_s, id: tail_id, ready: 1'b0, flush_needed: 1'b0};
         rob_q.push_back(ent);
         tail_id++;
      end
      if (last_head.ready) void'(rob_q.pop_front());
   endtask

   task automatic drive_line(input logic [35:0] line);
      logic [3:0] op;
      t_model_ent rec;
      op = line[35:32];
      if (op > 4'h4) stop_on_error($sformatf("Unknown operation %0h in the cases file", op));
      alloc_valid = (op == 4'h1);
      alloc_s = '{pc: line[31:16], rd: line[12:8]};
      wb_valid = (op == 4'h2);
      wb_result = '{robid: line[6:4], mispred: line[0]};
      rec = '{s: alloc_s, id: '0, ready: (op == 4'h3), flush_needed: (op == 4'h4)};
      if (rec.flush_needed) rec.s.rd = '0;
      if (rec.ready || rec.flush_needed) recorded.push_back(rec);
      model_step();
      // Pair predicted and recorded records in order
      while (predicted.size() > 0 && recorded.size() > 0) begin
         compare("retire or flush record", predicted.pop_front(), recorded.pop_front());
      end
   endtask

   // Watchdog allows 40 cycles per case line
   initial begin
      wait (n_cases > 0);
      repeat ((n_cases + 4) * 40) @(posedge clk);
      stop_on_error("Timeout before all expected retire and flush records were seen");
   end

   initial begin
      wait (rob_top_i.rob_chk_i.n_fail != 0);
      stop_on_error("An assertion in the bound checker failed");
   end

   initial begin
      reset = 1'b1;
      alloc_valid = 1'b0;
      alloc_s = '0;
      wb_valid = 1'b0;
      wb_result = '0;
      tail_id = '0;
      last_head = '0;
      n_cases = 0;
      foreach (case_mem[i]) case_mem[i] = 'x;
      $readmemh("tb/rob_cases.txt", case_mem);
      while (n_cases < MAX_LINES - 1 && case_mem[n_cases][35:32] != 4'hf) begin
         n_cases++;
      end
      if (case_mem[n_cases][35:32] !== 4'hf) begin
         stop_on_error("The cases file is missing or has no end marker");
      end
      repeat (4) @(negedge clk);
      reset = 1'b0;
      for (int k = 0; k < n_cases; k++) begin
         check_outputs();
         drive_line(case_mem[k]);
         @(negedge clk);
      end
      // Idle until every recorded retire and flush has shown up
      while (recorded.size() > 0) begin
         check_outputs();
         drive_line('0);
         @(negedge clk);
      end
      check_outputs();
      compare("unmatched predicted records", predicted.size(), 0);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
